// File: src/noc_config.svh
`ifndef NOC_CONFIG_SVH
`define NOC_CONFIG_SVH

// Flit data word, also the stream word width
`define NOC_FLIT_W 32

// Router destination field
`define NOC_DEST_W 4

// Words buffered per packetizer
`define NOC_FIFO_DEPTH 8

// Stream sources merged onto the link
`define NOC_NUM_SRC 2

`endif

// File: src/flit_pkg.sv
`include "noc_config.svh"

package flit_pkg;

  // Control field that travels beside every flit
  typedef struct packed {
    logic valid;
    logic head;
    logic tail;
  } flit_ctrl_t;

  localparam flit_ctrl_t HEAD_CTRL = '{valid: 1'b1, head: 1'b1, tail: 1'b0};  // 110
  localparam flit_ctrl_t TAIL_CTRL = '{valid: 1'b1, head: 1'b0, tail: 1'b1};  // 101

  typedef enum logic [2:0] {
    KIND_SINGLE = 3'b101  // One data word per packet
  } flit_kind_t;

  localparam int FLIT_RSVD_W = `NOC_FLIT_W - `NOC_DEST_W - 4;

  // Routing information in the head flit
  typedef struct packed {
    logic [`NOC_DEST_W-1:0]  dest;
    flit_kind_t              kind;
    logic                    src;   // Filled in by the link arbiter
    logic [FLIT_RSVD_W-1:0]  rsvd;  // Always zero
  } flit_head_t;

  // Same word read as routing header or as payload
  typedef union packed {
    flit_head_t              head;
    logic [`NOC_FLIT_W-1:0]  body;
  } flit_data_u;

endpackage

// File: src/stream_pkg.sv
`include "noc_config.svh"

package stream_pkg;

  // Destination carried on tdest
  typedef logic [`NOC_DEST_W-1:0] dest_t;

  // Number of the stream source a packet came from
  localparam int SRC_ID_W = (`NOC_NUM_SRC > 1) ? $clog2(`NOC_NUM_SRC) : 1;

  typedef logic [SRC_ID_W-1:0] src_id_t;

endpackage

// File: src/flit_fifo.sv
module flit_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 8
) (
  input  logic             clk,
  input  logic             rst,
  input  logic             wr_en,
  input  logic [WIDTH-1:0] din,
  input  logic             rd_en,
  output logic [WIDTH-1:0] dout,
  output logic             full,
  output logic             empty
);

  localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [AW-1:0]    wr_ptr;
  logic [AW-1:0]    rd_ptr;
  logic [CW-1:0]    count;
  logic             do_wr;
  logic             do_rd;

  // Pointer increment with wrap for any depth
  function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] ptr);
    if (ptr == AW'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign do_wr = wr_en && !full;   // Blocked when full
  assign do_rd = rd_en && !empty;  // Blocked when empty

  assign full  = (count == CW'(DEPTH));
  assign empty = (count == '0);
  assign dout  = mem[rd_ptr];  // Oldest entry, first-word fall-through

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_rd) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // Both or neither
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= din;
    end
  end

  // Upstream must respect full and empty
  a_no_overflow: assert property (@(posedge clk) disable iff (rst) !(wr_en && full))
    else $error("flit_fifo: write while full");
  a_no_underflow: assert property (@(posedge clk) disable iff (rst) !(rd_en && empty))
    else $error("flit_fifo: read while empty");

endmodule

// File: src/stream_packetizer.sv
`include "noc_config.svh"

module stream_packetizer (
  input  logic                   clk,
  input  logic                   rst,
  // AXI-Stream side
  input  logic                   tvalid,
  output logic                   tready,
  input  logic [`NOC_FLIT_W-1:0] tdata,
  input  stream_pkg::dest_t      tdest,
  // Flit side toward the arbiter
  output logic                   flit_valid,
  input  logic                   flit_ready,
  output flit_pkg::flit_ctrl_t   flit_ctrl,
  output flit_pkg::flit_data_u   flit_data
);

  import flit_pkg::*;
  import stream_pkg::*;

  localparam int ENTRY_W = `NOC_DEST_W + `NOC_FLIT_W;

  typedef enum logic {
    ST_HEAD,
    ST_TAIL
  } state_t;

  state_t               state;
  logic                 fifo_wr;
  logic                 fifo_rd;
  logic                 fifo_full;
  logic                 fifo_empty;
  logic [ENTRY_W-1:0]   fifo_dout;
  dest_t                q_dest;
  logic [`NOC_FLIT_W-1:0] q_data;
  logic                 flit_take;

  // Destination and data share one entry so they cannot drift apart
  flit_fifo #(
    .WIDTH (ENTRY_W),
    .DEPTH (`NOC_FIFO_DEPTH)
  ) fifo0 (
    .clk   (clk),
    .rst   (rst),
    .wr_en (fifo_wr),
    .din   ({tdest, tdata}),
    .rd_en (fifo_rd),
    .dout  (fifo_dout),
    .full  (fifo_full),
    .empty (fifo_empty)
  );

  assign tready  = !fifo_full;
  assign fifo_wr = tvalid && tready;

  assign q_dest = fifo_dout[ENTRY_W-1 -: `NOC_DEST_W];
  assign q_data = fifo_dout[`NOC_FLIT_W-1:0];

  assign flit_valid = !fifo_empty;  // Same word feeds both flits
  assign flit_take  = flit_valid && flit_ready;
  assign fifo_rd    = flit_take && (state == ST_TAIL);  // Pop once the payload is gone

  always_comb begin
    if (state == ST_HEAD) begin
      flit_ctrl      = HEAD_CTRL;
      flit_data.head = '{dest: q_dest, kind: KIND_SINGLE, src: 1'b0, rsvd: '0};
    end else begin
      flit_ctrl      = TAIL_CTRL;
      flit_data.body = q_data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state <= ST_HEAD;
    end else if (flit_take) begin
      case (state)
        ST_HEAD: state <= ST_TAIL;
        ST_TAIL: state <= ST_HEAD;
        default: state <= ST_HEAD;
      endcase
    end
  end

endmodule

// File: src/link_arbiter.sv
module link_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 in0_valid,
  output logic                 in0_ready,
  input  flit_pkg::flit_ctrl_t in0_ctrl,
  input  flit_pkg::flit_data_u in0_data,
  input  logic                 in1_valid,
  output logic                 in1_ready,
  input  flit_pkg::flit_ctrl_t in1_ctrl,
  input  flit_pkg::flit_data_u in1_data,
  output logic                 link_valid,
  input  logic                 link_ready,
  output flit_pkg::flit_ctrl_t link_ctrl,
  output flit_pkg::flit_data_u link_data
);

  import flit_pkg::*;
  import stream_pkg::*;

  logic       req0;
  logic       req1;
  logic       locked;   // Grant frozen inside a packet
  src_id_t    last;     // Source of the latest head
  src_id_t    gnt;
  logic       gnt_vld;
  logic       can_take;
  logic       take;
  flit_ctrl_t sel_ctrl;
  flit_data_u sel_data;
  logic       out_vld;
  flit_ctrl_t out_ctrl;
  flit_data_u out_data;

  // Only a head flit may open a new grant
  assign req0 = in0_valid && in0_ctrl.head;
  assign req1 = in1_valid && in1_ctrl.head;

  always_comb begin
    if (locked) begin
      gnt     = last;
      gnt_vld = last[0] ? in1_valid : in0_valid;
    end else if (req0 && req1) begin
      gnt     = ~last;  // Round robin
      gnt_vld = 1'b1;
    end else begin
      gnt     = src_id_t'(req1);
      gnt_vld = req0 || req1;
    end
    sel_ctrl = gnt[0] ? in1_ctrl : in0_ctrl;
    sel_data = gnt[0] ? in1_data : in0_data;
    if (sel_ctrl.head) begin
      sel_data.head.src = gnt;  // Stamp the source number
    end
  end

  assign can_take  = !out_vld || link_ready;  // Empty or draining this cycle
  assign take      = can_take && gnt_vld;
  assign in0_ready = can_take && gnt_vld && (gnt == src_id_t'(0));
  assign in1_ready = can_take && gnt_vld && (gnt == src_id_t'(1));

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      out_vld <= 1'b0;
      locked  <= 1'b0;
      last    <= src_id_t'(1);  // Source 0 wins the first tie
    end else begin
      if (take) begin
        out_vld <= 1'b1;
      end else if (link_ready) begin
        out_vld <= 1'b0;
      end
      if (take && sel_ctrl.head) begin
        locked <= 1'b1;
        last   <= gnt;
      end else if (take && sel_ctrl.tail) begin
        locked <= 1'b0;  // Packet done
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      out_ctrl <= sel_ctrl;
      out_data <= sel_data;
    end
  end

  assign link_valid = out_vld;
  assign link_ctrl  = out_ctrl;
  assign link_data  = out_data;

  // Router sees a steady flit while it stalls
  a_link_stable: assert property (@(posedge clk) disable iff (rst)
    link_valid && !link_ready |=> link_valid && $stable(link_ctrl) && $stable(link_data))
    else $error("link_arbiter: stalled flit changed");

  // Only the owner's tail may pass inside a packet
  a_no_interleave: assert property (@(posedge clk) disable iff (rst)
    locked && take |-> sel_ctrl.tail && (gnt == last))
    else $error("link_arbiter: grant changed inside a packet");

endmodule

// File: src/noc_inject_top.sv
`include "noc_config.svh"

module noc_inject_top (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   s0_tvalid,
  output logic                   s0_tready,
  input  logic [`NOC_FLIT_W-1:0] s0_tdata,
  input  stream_pkg::dest_t      s0_tdest,
  input  logic                   s1_tvalid,
  output logic                   s1_tready,
  input  logic [`NOC_FLIT_W-1:0] s1_tdata,
  input  stream_pkg::dest_t      s1_tdest,
  output logic                   link_valid,
  input  logic                   link_ready,
  output flit_pkg::flit_ctrl_t   link_ctrl,
  output flit_pkg::flit_data_u   link_data
);

  import flit_pkg::*;

  // One flit channel per source between packetizer and arbiter
  logic [`NOC_NUM_SRC-1:0] pk_valid;
  logic [`NOC_NUM_SRC-1:0] pk_ready;
  flit_ctrl_t              pk_ctrl [`NOC_NUM_SRC];
  flit_data_u              pk_data [`NOC_NUM_SRC];

  stream_packetizer pkt0 (
    .clk        (clk),
    .rst        (rst),
    .tvalid     (s0_tvalid),
    .tready     (s0_tready),
    .tdata      (s0_tdata),
    .tdest      (s0_tdest),
    .flit_valid (pk_valid[0]),
    .flit_ready (pk_ready[0]),
    .flit_ctrl  (pk_ctrl[0]),
    .flit_data  (pk_data[0])
  );

  stream_packetizer pkt1 (
    .clk        (clk),
    .rst        (rst),
    .tvalid     (s1_tvalid),
    .tready     (s1_tready),
    .tdata      (s1_tdata),
    .tdest      (s1_tdest),
    .flit_valid (pk_valid[1]),
    .flit_ready (pk_ready[1]),
    .flit_ctrl  (pk_ctrl[1]),
    .flit_data  (pk_data[1])
  );

  link_arbiter arb0 (
    .clk        (clk),
    .rst        (rst),
    .in0_valid  (pk_valid[0]),
    .in0_ready  (pk_ready[0]),
    .in0_ctrl   (pk_ctrl[0]),
    .in0_data   (pk_data[0]),
    .in1_valid  (pk_valid[1]),
    .in1_ready  (pk_ready[1]),
    .in1_ctrl   (pk_ctrl[1]),
    .in1_data   (pk_data[1]),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_ctrl  (link_ctrl),
    .link_data  (link_data)
  );

endmodule

// File: sim/tb_noc_inject.sv
`include "noc_config.svh"

module tb_noc_inject;

  import flit_pkg::*;

  localparam int NUM_ENTRIES = 28;
  localparam int CYCLE_LIMIT = NUM_ENTRIES * 20 + 100;

  // Each entry holds phase, source, destination, gap cycles and payload
  localparam logic [51:0] STIM [NUM_ENTRIES] = '{
    52'h2_0_3_00_a0000001,
    52'h2_0_7_02_a0000002,
    52'h2_1_5_00_b0000001,
    52'h2_1_c_01_b0000002,
    52'h3_0_1_00_c0000001,
    52'h3_0_2_00_c0000002,
    52'h3_0_3_00_c0000003,
    52'h3_1_9_00_d0000001,
    52'h3_1_a_00_d0000002,
    52'h3_1_b_00_d0000003,
    52'h4_0_4_01_e0000001,
    52'h4_0_0_00_e0000002,
    52'h4_0_f_03_e0000003,
    52'h4_0_6_00_e0000004,
    52'h4_1_8_00_f0000001,
    52'h4_1_2_02_f0000002,
    52'h4_1_e_00_f0000003,
    52'h4_1_1_01_f0000004,
    52'h5_0_1_00_12340001,
    52'h5_0_2_00_12340002,
    52'h5_0_3_00_12340003,
    52'h5_0_4_00_12340004,
    52'h5_0_5_00_12340005,
    52'h5_0_6_00_12340006,
    52'h5_0_7_00_12340007,
    52'h5_0_8_00_12340008,
    52'h5_0_9_00_12340009,
    52'h5_0_a_00_1234000a
  };

  logic                   clk;
  logic                   rst;
  logic                   s0_tvalid;
  logic                   s0_tready;
  logic [`NOC_FLIT_W-1:0] s0_tdata;
  logic [`NOC_DEST_W-1:0] s0_tdest;
  logic                   s1_tvalid;
  logic                   s1_tready;
  logic [`NOC_FLIT_W-1:0] s1_tdata;
  logic [`NOC_DEST_W-1:0] s1_tdest;
  logic                   link_valid;
  logic                   link_ready;
  flit_ctrl_t             link_ctrl;
  flit_data_u             link_data;

  logic [67:0] exp0 [$];  // {accept edge, dest, payload}
  logic [67:0] exp1 [$];
  int          cyc = 0;
  int          checks = 0;
  int          errors = 0;
  int          mark = 0;
  int          tests = 0;
  int          ready_mode = 0;  // 0 always ready, 1 random, 2 held low
  logic        in_packet = 1'b0;
  logic        cur_src = 1'b0;
  int          last_xfer = -10;
  logic        stalled = 1'b0;
  flit_ctrl_t  held_ctrl;
  flit_data_u  held_data;

  noc_inject_top dut0 (
    .clk        (clk),
    .rst        (rst),
    .s0_tvalid  (s0_tvalid),
    .s0_tready  (s0_tready),
    .s0_tdata   (s0_tdata),
    .s0_tdest   (s0_tdest),
    .s1_tvalid  (s1_tvalid),
    .s1_tready  (s1_tready),
    .s1_tdata   (s1_tdata),
    .s1_tdest   (s1_tdest),
    .link_valid (link_valid),
    .link_ready (link_ready),
    .link_ctrl  (link_ctrl),
    .link_data  (link_data)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;  // Rising edges so far
    if (cyc >= CYCLE_LIMIT) begin
      $display("error: timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("Simulation failed");
      $finish;
    end
  end

  task automatic compare(input logic ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("mismatch at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic require(input logic ok, input string msg);
    checks++;
    assert (ok) else begin
      $display("error at %0t: %s", $time, msg);
      errors++;
    end
  endtask

  task automatic push_expected(input int src, input logic [3:0] dest, input logic [31:0] data);
    if (src == 0) begin
      exp0.push_back({32'(cyc + 1), dest, data});
    end else begin
      exp1.push_back({32'(cyc + 1), dest, data});
    end
  endtask

  // Starts on a falling edge and returns on the one after the transfer
  task automatic send_word(input int src, input logic [3:0] dest, input logic [31:0] data);
    logic done;
    done = 1'b0;
    if (src == 0) begin
      s0_tvalid = 1'b1;
      s0_tdest  = dest;
      s0_tdata  = data;
    end else begin
      s1_tvalid = 1'b1;
      s1_tdest  = dest;
      s1_tdata  = data;
    end
    while (!done) begin
      done = (src == 0) ? s0_tready : s1_tready;  // Full only changes on the rising edge
      if (done) begin
        push_expected(src, dest, data);
      end
      @(negedge clk);
    end
    if (src == 0) begin
      s0_tvalid = 1'b0;
    end else begin
      s1_tvalid = 1'b0;
    end
  endtask

  task automatic send_words(input int src, input int phase);
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (int'(STIM[i][51:48]) == phase && int'(STIM[i][47:44]) == src) begin
        send_word(src, STIM[i][43:40], STIM[i][31:0]);
        repeat (int'(STIM[i][39:32])) @(negedge clk);
      end
    end
  endtask

  // Flit that transfers on the coming rising edge
  task automatic check_flit();
    logic [67:0] front;
    logic [67:0] other;
    logic        s;
    int          pending;
    if (!in_packet) begin
      s = link_data.head.src;
      pending = s ? exp1.size() : exp0.size();
      compare(link_ctrl == 3'b110, $sformatf("head ctrl %b, expected 110", link_ctrl));
      compare(link_data.head.kind == KIND_SINGLE && link_data.head.rsvd == '0,
              $sformatf("head kind or reserved bits wrong in %h", link_data.body));
      require(pending != 0, $sformatf("head flit from source %0d with no word pending", s));
      if (pending != 0) begin
        front = s ? exp1[0] : exp0[0];
        compare(link_data.head.dest == front[35:32],
                $sformatf("source %0d dest %h, expected %h", s, link_data.head.dest,
                          front[35:32]));
      end
      // Same source twice in a row only if the other had nothing buffered
      if (last_xfer == cyc && s == cur_src && (s ? exp0.size() : exp1.size()) != 0) begin
        other = s ? exp0[0] : exp1[0];
        compare(int'(other[67:36]) >= cyc,
                $sformatf("source %0d served twice while source %0d waited", s, !s));
      end
      cur_src   = s;
      in_packet = 1'b1;
    end else begin
      pending = cur_src ? exp1.size() : exp0.size();
      compare(link_ctrl == 3'b101, $sformatf("tail ctrl %b, expected 101", link_ctrl));
      require(pending != 0, "tail flit with no word pending");
      if (pending != 0) begin
        front = cur_src ? exp1[0] : exp0[0];
        compare(link_data.body == front[31:0],
                $sformatf("source %0d payload %h, expected %h", cur_src, link_data.body,
                          front[31:0]));
        if (cur_src) begin
          void'(exp1.pop_front());
        end else begin
          void'(exp0.pop_front());
        end
      end
      in_packet = 1'b0;
    end
  endtask

  // Router model sampling the link while clk is low
  initial begin
    logic ready;
    void'($urandom(4));
    link_ready = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (stalled) begin
          compare(link_valid && link_ctrl == held_ctrl && link_data == held_data,
                  "stalled flit changed on the link");
        end
        case (ready_mode)
          0:       ready = 1'b1;
          1:       ready = ($urandom % 10) < 7;
          default: ready = 1'b0;
        endcase
        link_ready = ready;
        stalled    = link_valid && !ready;
        held_ctrl  = link_ctrl;
        held_data  = link_data;
        if (link_valid && ready) begin
          check_flit();
          last_xfer = cyc + 1;
        end
      end
    end
  end

  task automatic wait_drain();
    do begin
      @(posedge clk);
    end while (exp0.size() != 0 || exp1.size() != 0);
    repeat (2) @(negedge clk);
  endtask

  task automatic close_test(input string name);
    $display("test %s: %0d errors", name, errors - mark);
    mark = errors;
    tests++;
  endtask

  initial begin
    rst       = 1'b1;
    s0_tvalid = 1'b0;
    s0_tdata  = '0;
    s0_tdest  = '0;
    s1_tvalid = 1'b0;
    s1_tdata  = '0;
    s1_tdest  = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    compare(!link_valid && s0_tready && s1_tready, "link_valid or tready wrong after reset");
    close_test("1 reset state");

    send_words(0, 2);
    send_words(1, 2);
    wait_drain();
    close_test("2 single source packets");

    fork
      send_words(0, 3);
      send_words(1, 3);
    join
    wait_drain();
    close_test("3 round robin between sources");

    @(posedge clk) ready_mode = 1;
    @(negedge clk);
    fork
      send_words(0, 4);
      send_words(1, 4);
    join
    wait_drain();
    close_test("4 random back-pressure");

    @(posedge clk) ready_mode = 2;
    @(negedge clk);
    fork
      send_words(0, 5);
      begin
        while (s0_tready) @(negedge clk);
        compare(exp0.size() >= `NOC_FIFO_DEPTH, "tready dropped before the FIFO was full");
        @(posedge clk) ready_mode = 1;
      end
    join
    wait_drain();
    close_test("5 full FIFO under stall");

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: compile.f
+incdir+src
src/flit_pkg.sv
src/stream_pkg.sv
src/flit_fifo.sv
src/stream_packetizer.sv
src/link_arbiter.sv
src/noc_inject_top.sv
sim/tb_noc_inject.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f compile.f --top-module tb_noc_inject -o tb_noc_inject

out=$(./obj_dir/tb_noc_inject)
echo "$out"

if echo "$out" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
